// File: logic/bpu_pkg.sv
package bpu_pkg;

    // 2-bit saturating counter, taken when 2 or more
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_taken = 2'd2;
    localparam ctr_t ctr_max        = 2'd3;
    localparam ctr_t ctr_min        = 2'd0;

    // training record from the back end
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } bpu_update_t;

    // lookup result
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } bpu_pred_t;

    function automatic ctr_t ctr_inc(ctr_t c);
        return (c == ctr_max) ? c : c + 2'd1;
    endfunction

    function automatic ctr_t ctr_dec(ctr_t c);
        return (c == ctr_min) ? c : c - 2'd1;
    endfunction

endpackage

// File: logic/branch_predictor.sv
module branch_predictor #(
    parameter int btb_index_bits = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          lookup_pc,
    output bpu_pkg::bpu_pred_t   pred,
    input  bpu_pkg::bpu_update_t update
);
    import bpu_pkg::*;

    localparam int entries  = 1 << btb_index_bits;
    // pc bits above the index, word offset excluded
    localparam int tag_bits = 30 - btb_index_bits;

    logic [entries-1:0]        ent_valid;
    logic [tag_bits-1:0]       ent_tag    [entries];
    logic [31:0]               ent_target [entries];
    ctr_t                      ent_ctr    [entries];

    logic [btb_index_bits-1:0] look_idx;
    logic [tag_bits-1:0]       look_tag;
    logic                      look_hit;
    logic [btb_index_bits-1:0] upd_idx;
    logic [tag_bits-1:0]       upd_tag;
    logic                      upd_hit;

    // lookup, combinational
    assign look_idx = lookup_pc[btb_index_bits+1:2];
    assign look_tag = lookup_pc[31:btb_index_bits+2];
    assign look_hit = ent_valid[look_idx] && (ent_tag[look_idx] == look_tag);

    assign pred.taken  = look_hit && (ent_ctr[look_idx] >= ctr_weak_taken);
    assign pred.target = ent_target[look_idx];

    // training side
    assign upd_idx = update.pc[btb_index_bits+1:2];
    assign upd_tag = update.pc[31:btb_index_bits+2];
    assign upd_hit = ent_valid[upd_idx] && (ent_tag[upd_idx] == upd_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= '0;
        end else if (update.valid && update.taken && !upd_hit) begin
            ent_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            if (update.taken) begin
                ent_target[upd_idx] <= update.target;
                if (upd_hit) begin
                    ent_ctr[upd_idx] <= ctr_inc(ent_ctr[upd_idx]);
                end else begin
                    // new entry starts weakly taken
                    ent_tag[upd_idx] <= upd_tag;
                    ent_ctr[upd_idx] <= ctr_weak_taken;
                end
            end else if (upd_hit) begin
                ent_ctr[upd_idx] <= ctr_dec(ent_ctr[upd_idx]);
            end
        end
    end

endmodule

// File: logic/fetch_bus_if.sv
interface fetch_bus_if;

    // offered fetch address
    logic        valid;
    logic [31:0] pc;
    // low two pc bits not zero
    logic        adel;

    // fetch stage can take a new entry
    logic        allowin;

    // transfer when valid and allowin are both high at the edge

    modport sender (
        output valid,
        output pc,
        output adel,
        input  allowin
    );

    modport receiver (
        input  valid,
        input  pc,
        input  adel,
        output allowin
    );

endinterface

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // major opcode field of an instruction
    // fetch only cares about the two absolute jumps
    typedef enum logic [5:0] {
        op_other = 6'b000000,
        op_j     = 6'b000010,
        op_jal   = 6'b000011
    } opcode_t;

    // cp0 exception codes seen at fetch
    typedef enum logic [4:0] {
        exc_none = 5'h00,
        // address error on instruction load
        exc_adel = 5'h04
    } exc_code_t;

    // word handed to decode for a misaligned fetch
    localparam logic [31:0] inst_zero = 32'h0000_0000;

    // bundle toward decode, 102 bits
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        exc_code_t   exc;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_out_t;

    // j and jal share the upper five opcode bits
    function automatic logic is_jump(logic [31:0] inst);
        opcode_t op;
        op = opcode_t'(inst[31:26]);
        return (op == op_j) || (op == op_jal);
    endfunction

    // region of the jump's own pc, no delay slot
    function automatic logic [31:0] jump_target(
        logic [31:0] pc,
        logic [31:0] inst
    );
        return {pc[31:28], inst[25:0], 2'b00};
    endfunction

endpackage

// File: logic/fetch_stage.sv
module fetch_stage #(
    parameter int btb_index_bits = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    fetch_bus_if.receiver         bus,
    input  logic                  icache_busy,
    input  logic [31:0]           inst_rdata,
    input  logic                  flush_valid,
    input  bpu_pkg::bpu_pred_t    pred,
    output logic [31:0]           lookup_pc,
    output logic                  redirect_next,
    output logic [31:0]           redirect_target,
    output fetch_pkg::fetch_out_t out,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import fetch_pkg::*;

    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_adel;
    logic        have_inst;
    logic [31:0] inst_r;
    logic        pred_lat;
    logic        pred_taken_r;
    logic [31:0] pred_target_r;
    logic        ready_go;
    logic        accept;
    logic [31:0] fs_inst;
    logic        jump;
    logic        use_taken;
    logic [31:0] use_target;
    logic [31:0] steer_target;

    // misaligned entries skip the memory wait
    assign ready_go    = fs_adel || have_inst || !icache_busy;
    assign bus.allowin = !fs_valid || (ready_go && out_ready);
    assign accept      = bus.valid && bus.allowin;
    assign out_valid   = fs_valid && ready_go && !flush_valid;

    always_ff @(posedge clk) begin
        if (reset || flush_valid) begin
            fs_valid  <= 1'b0;
            have_inst <= 1'b0;
            pred_lat  <= 1'b0;
        end else begin
            if (bus.allowin) begin
                fs_valid <= bus.valid;
            end
            if (accept) begin
                have_inst <= 1'b0;
                pred_lat  <= 1'b0;
            end else begin
                if (fs_valid && !icache_busy) begin
                    have_inst <= 1'b1;
                end
                // freeze the prediction while stalled at the output
                if (out_valid) begin
                    pred_lat <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fs_pc   <= bus.pc;
            fs_adel <= bus.adel;
        end
        // memory data is only good while not busy
        if (fs_valid && !have_inst && !icache_busy) begin
            inst_r <= inst_rdata;
        end
        if (out_valid && !pred_lat) begin
            pred_taken_r  <= pred.taken;
            pred_target_r <= pred.target;
        end
    end

    assign fs_inst = fs_adel ? inst_zero : (have_inst ? inst_r : inst_rdata);

    // jump predecode wins over the btb
    assign jump         = is_jump(fs_inst);
    assign use_taken    = pred_lat ? pred_taken_r : pred.taken;
    assign use_target   = pred_lat ? pred_target_r : pred.target;
    assign steer_target = jump ? jump_target(fs_pc, fs_inst) : use_target;

    assign lookup_pc       = fs_pc;
    assign redirect_next   = fs_valid && ready_go && (jump || use_taken);
    assign redirect_target = steer_target;

    assign out.pc          = fs_pc;
    assign out.inst        = fs_inst;
    assign out.exc         = fs_adel ? exc_adel : exc_none;
    assign out.pred_taken  = jump || use_taken;
    assign out.pred_target = steer_target;

endmodule

// File: logic/fetch_top.sv
module fetch_top #(
    parameter int          btb_index_bits = 4,
    parameter logic [31:0] reset_pc       = 32'h0000_1000
) (
    input  logic                 clk,
    input  logic                 reset,
    // instruction memory
    output logic                 inst_req,
    output logic [31:0]          inst_addr,
    input  logic                 icache_busy,
    input  logic [31:0]          inst_rdata,
    // decode
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [31:0]          out_pc,
    output logic [31:0]          out_inst,
    output fetch_pkg::exc_code_t out_exc,
    output logic                 out_pred_taken,
    output logic [31:0]          out_pred_target,
    // back end
    input  logic                 flush_valid,
    input  logic [31:0]          flush_pc,
    input  logic                 upd_valid,
    input  logic [31:0]          upd_pc,
    input  logic                 upd_taken,
    input  logic [31:0]          upd_target
);
    import fetch_pkg::*;
    import bpu_pkg::*;

    fetch_bus_if fetch_bus ();

    bpu_pred_t   pred;
    bpu_update_t update;
    fetch_out_t  fs_out;
    logic [31:0] lookup_pc;
    logic        redirect_next;
    logic [31:0] redirect_target;

    assign update = '{valid: upd_valid, pc: upd_pc, taken: upd_taken, target: upd_target};

    assign out_pc          = fs_out.pc;
    assign out_inst        = fs_out.inst;
    assign out_exc         = fs_out.exc;
    assign out_pred_taken  = fs_out.pred_taken;
    assign out_pred_target = fs_out.pred_target;

    pc_gen #(
        .reset_pc (reset_pc)
    ) u_pc_gen (
        .clk             (clk),
        .reset           (reset),
        .bus             (fetch_bus.sender),
        .redirect_next   (redirect_next),
        .redirect_target (redirect_target),
        .flush_valid     (flush_valid),
        .flush_pc        (flush_pc),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr)
    );

    fetch_stage #(
        .btb_index_bits (btb_index_bits)
    ) u_fetch_stage (
        .clk             (clk),
        .reset           (reset),
        .bus             (fetch_bus.receiver),
        .icache_busy     (icache_busy),
        .inst_rdata      (inst_rdata),
        .flush_valid     (flush_valid),
        .pred            (pred),
        .lookup_pc       (lookup_pc),
        .redirect_next   (redirect_next),
        .redirect_target (redirect_target),
        .out             (fs_out),
        .out_valid       (out_valid),
        .out_ready       (out_ready)
    );

    branch_predictor #(
        .btb_index_bits (btb_index_bits)
    ) u_branch_predictor (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (lookup_pc),
        .pred      (pred),
        .update    (update)
    );

endmodule

// File: logic/pc_gen.sv
module pc_gen #(
    parameter logic [31:0] reset_pc = 32'h0000_1000
) (
    input  logic        clk,
    input  logic        reset,
    fetch_bus_if.sender bus,
    input  logic        redirect_next,
    input  logic [31:0] redirect_target,
    input  logic        flush_valid,
    input  logic [31:0] flush_pc,
    output logic        inst_req,
    output logic [31:0] inst_addr
);

    logic [31:0] pc_r;
    logic [31:0] fetch_pc;
    logic        misaligned;
    logic        xfer;

    // held instruction steers the address before it is requested,
    // so nothing off the predicted path reaches memory
    assign fetch_pc = redirect_next ? redirect_target : pc_r;

    assign misaligned = fetch_pc[1:0] != 2'b00;

    // always something to offer, except while held in reset or flushing
    assign bus.valid = !reset && !flush_valid;
    assign bus.pc    = fetch_pc;
    assign bus.adel  = misaligned;

    assign xfer = bus.valid && bus.allowin;

    // misaligned addresses never go to memory
    assign inst_req  = xfer && !misaligned;
    assign inst_addr = fetch_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_r <= reset_pc;
        end else if (flush_valid) begin
            pc_r <= flush_pc;
        end else if (xfer) begin
            pc_r <= fetch_pc + 32'd4;
        end
    end

endmodule

// File: sim/fetch_checker.sv
module fetch_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 inst_req,
    input logic                 flush_valid,
    input logic                 out_valid,
    input logic                 out_ready,
    input logic [31:0]          out_pc,
    input logic [31:0]          out_inst,
    input fetch_pkg::exc_code_t out_exc,
    input logic                 out_pred_taken,
    input logic [31:0]          out_pred_target
);

    int   fail_count = 0;
    // reset also held on the previous edge, registers cleared by now
    logic reset_d;

    always_ff @(posedge clk) begin
        reset_d <= reset;
    end

    reset_quiet: assert property (
        @(posedge clk) reset && reset_d |-> !out_valid && !inst_req
    ) else begin
        fail_count++;
        $error("decode output or memory request active during reset");
    end

    // a stalled output either holds or is dropped by a flush
    stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> flush_valid || (out_valid && $stable(out_pc)
            && $stable(out_inst) && $stable(out_exc) && $stable(out_pred_taken)
            && (!out_pred_taken || $stable(out_pred_target)))
    ) else begin
        fail_count++;
        $error("decode outputs changed while stalled");
    end

    no_req_in_flush: assert property (
        @(posedge clk) disable iff (reset)
        flush_valid |-> !inst_req
    ) else begin
        fail_count++;
        $error("memory request issued during a flush");
    end

endmodule

bind fetch_top fetch_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .inst_req        (inst_req),
    .flush_valid     (flush_valid),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_pc          (out_pc),
    .out_inst        (out_inst),
    .out_exc         (out_exc),
    .out_pred_taken  (out_pred_taken),
    .out_pred_target (out_pred_target)
);

// File: sim/fetch_tb.sv
module fetch_tb;
    import fetch_pkg::*;
    import bpu_pkg::*;

    localparam logic [31:0] reset_pc    = 32'h0000_1000;
    localparam logic [31:0] region_base = 32'h0000_1000;
    localparam int          num_outputs = 2000;
    localparam int          idle_limit  = 200;

    logic        clk;
    logic        reset;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        icache_busy;
    logic [31:0] inst_rdata;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    exc_code_t   out_exc;
    logic        out_pred_taken;
    logic [31:0] out_pred_target;
    logic        flush_valid;
    logic [31:0] flush_pc;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic [31:0] upd_target;

    logic [31:0] lfsr;
    logic [31:0] last_addr;
    logic        have_req;
    logic [31:0] exp_pc;
    logic        frozen;
    logic        exp_taken;
    logic [31:0] exp_target;
    // model btb, 16 entries
    logic        m_valid  [16];
    logic [25:0] m_tag    [16];
    logic [31:0] m_target [16];
    ctr_t        m_ctr    [16];
    int          accepted;
    int          idle;
    int          check_count;
    int          error_count;
    bit          timed_out;

    fetch_top #(
        .btb_index_bits (4),
        .reset_pc       (reset_pc)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr),
        .icache_busy     (icache_busy),
        .inst_rdata      (inst_rdata),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_pc          (out_pc),
        .out_inst        (out_inst),
        .out_exc         (out_exc),
        .out_pred_taken  (out_pred_taken),
        .out_pred_target (out_pred_target),
        .flush_valid     (flush_valid),
        .flush_pc        (flush_pc),
        .upd_valid       (upd_valid),
        .upd_pc          (upd_pc),
        .upd_taken       (upd_taken),
        .upd_target      (upd_target)
    );

    // one step of a 32-bit galois lfsr
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // memory contents, roughly one word in eight jumps back into the region
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        logic [31:0] tgt;
        opcode_t     op;
        h = (addr ^ 32'h3c6e_f372) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        tgt = region_base + (h[11:6] << 2);
        op = h[3] ? op_jal : op_j;
        if (h[2:0] == 3'd0) begin
            return {op, tgt[27:2]};
        end
        // opcodes 32 and up are never jumps
        return {h[31:26] | 6'b100000, h[25:0]};
    endfunction

    function automatic logic [31:0] exp_inst(input logic [31:0] pc);
        return (pc[1:0] != 2'b00) ? 32'h0 : mem_word(pc);
    endfunction

    // steering for a shown pc, jump predecode before the btb
    task automatic predict(input logic [31:0] pc);
        logic [31:0] inst;
        logic [3:0]  idx;
        logic        jump;
        inst = exp_inst(pc);
        idx  = pc[5:2];
        jump = (inst[31:26] == op_j) || (inst[31:26] == op_jal);
        if (jump) begin
            exp_taken  = 1'b1;
            exp_target = {pc[31:28], inst[25:0], 2'b00};
        end else if (m_valid[idx] && (m_tag[idx] == pc[31:6]) && (m_ctr[idx] >= 2'd2)) begin
            exp_taken  = 1'b1;
            exp_target = m_target[idx];
        end else begin
            exp_taken  = 1'b0;
            exp_target = pc + 32'd4;
        end
    endtask

    task automatic train(input logic [31:0] pc, input logic taken,
                         input logic [31:0] target);
        logic [3:0] idx;
        logic       hit;
        idx = pc[5:2];
        hit = m_valid[idx] && (m_tag[idx] == pc[31:6]);
        if (taken) begin
            m_target[idx] = target;
            if (!hit) begin
                m_valid[idx] = 1'b1;
                m_tag[idx]   = pc[31:6];
                m_ctr[idx]   = 2'd2;
            end else if (m_ctr[idx] != 2'd3) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end
        end else if (hit && (m_ctr[idx] != 2'd0)) begin
            m_ctr[idx] = m_ctr[idx] - 2'd1;
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_cycle();
        out_ready   = rand_bits(2) != 0;
        icache_busy = rand_bits(3) < 3;
        // busy cycles carry junk
        inst_rdata  = (have_req && !icache_busy) ? mem_word(last_addr) : rand_bits(32);
        flush_valid = rand_bits(6) == 0;
        flush_pc    = region_base + (rand_bits(6) << 2);
        if (rand_bits(3) == 0) begin
            flush_pc = flush_pc + 32'd1 + (rand_bits(1) << 1);
        end
        upd_valid  = rand_bits(2) == 0;
        upd_pc     = region_base + (rand_bits(6) << 2);
        upd_taken  = rand_bits(2) != 0;
        upd_target = region_base + (rand_bits(6) << 2);
    endtask

    task automatic observe_cycle();
        if (inst_req) begin
            check_eq("request address low bits", inst_addr[1:0], 2'b00);
            last_addr = inst_addr;
            have_req  = 1'b1;
        end
        if (flush_valid) begin
            check_eq("out_valid during flush", out_valid, 1'b0);
            exp_pc = flush_pc;
            frozen = 1'b0;
        end else if (out_valid) begin
            // prediction fixed by the first cycle the output shows
            if (!frozen) begin
                predict(exp_pc);
                frozen = 1'b1;
            end
            check_eq("out_pc", out_pc, exp_pc);
            check_eq("out_inst", out_inst, exp_inst(exp_pc));
            check_eq("out_exc", out_exc, (exp_pc[1:0] != 2'b00) ? exc_adel : exc_none);
            check_eq("out_pred_taken", out_pred_taken, exp_taken);
            if (exp_taken) begin
                check_eq("out_pred_target", out_pred_target, exp_target);
            end
            if (out_ready) begin
                exp_pc = exp_target;
                frozen = 1'b0;
                accepted++;
                idle = 0;
            end
        end
        // training lands at the coming edge, after this cycle's lookup
        if (upd_valid) begin
            train(upd_pc, upd_taken, upd_target);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        reset       = 1'b1;
        out_ready   = 1'b0;
        icache_busy = 1'b1;
        inst_rdata  = '0;
        flush_valid = 1'b0;
        flush_pc    = '0;
        upd_valid   = 1'b0;
        upd_pc      = '0;
        upd_taken   = 1'b0;
        upd_target  = '0;
        lfsr        = 32'd63;
        last_addr   = '0;
        have_req    = 1'b0;
        exp_pc      = reset_pc;
        frozen      = 1'b0;
        exp_taken   = 1'b0;
        exp_target  = '0;
        accepted    = 0;
        idle        = 0;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_ctr[i]    = 2'd0;
        end
        repeat (16) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        drive_cycle();
        while (accepted < num_outputs && !timed_out) begin
            @(negedge clk);
            idle++;
            observe_cycle();
            if (idle > idle_limit) begin
                $display("timeout: no output accepted for %0d cycles", idle_limit);
                error_count++;
                timed_out = 1'b1;
            end
            @(posedge clk);
            #1;
            drive_cycle();
        end
        $display("outputs %0d, checks %0d, errors %0d, assertion failures %0d",
                 accepted, check_count, error_count, dut.u_checker.fail_count);
        if (error_count == 0 && dut.u_checker.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/fetch_pkg.sv
logic/bpu_pkg.sv
logic/fetch_bus_if.sv
logic/pc_gen.sv
logic/fetch_stage.sv
logic/branch_predictor.sv
logic/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv
